// ==== verilog.f ====
ossc_out_pkg.sv
capture_select.sv
osd_overlay_out.sv
status_led.sv
fan_led_pwm.sv
ossc_out_top.sv
tb_ossc_out.sv

// ==== Makefile ====
TOP = tb_ossc_out

.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/10ps -f verilog.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== tb_ossc_out.sv ====
`timescale 1ns/10ps

module tb_ossc_out;

    localparam int TABLE_LEN = 24;
    localparam int RESYNC_SPAN = 1 << ossc_out_pkg::RESYNC_CTR_W;
    localparam int BLINK_HALF = 1 << (ossc_out_pkg::RESYNC_CTR_W - 1);
    localparam int WATCHDOG_CYCLES = TABLE_LEN + 3 * RESYNC_SPAN + 4 * ossc_out_pkg::PWM_PERIOD;

    typedef struct packed {
        logic capture_sel;
        ossc_out_pkg::video_pixel_t isl_pix;
        ossc_out_pkg::video_pixel_t hdmi_pix;
        logic datavalid;
        logic osd_enable;
        ossc_out_pkg::osd_color_e osd_color;
        ossc_out_pkg::video_pixel_t exp_pix;
    } table_entry_t;

    logic pclk_out;
    logic po_reset_n;
    ossc_out_pkg::sys_ctrl_t sys_ctrl;
    ossc_out_pkg::video_pixel_t isl_pix;
    ossc_out_pkg::video_pixel_t hdmirx_pix;
    logic isl_datavalid;
    logic osd_enable;
    ossc_out_pkg::osd_color_e osd_color;
    logic resync_strobe;
    logic pll_locked;
    ossc_out_pkg::video_pixel_t hdmitx_pix;
    logic [1:0] led;
    logic fan_pwm_n;

    table_entry_t stim_table[TABLE_LEN];
    int seed = 24;
    int error_count = 0;
    int check_count = 0;

    ossc_out_top DUT (
        .pclk_out        (pclk_out),
        .po_reset_n      (po_reset_n),
        .sys_ctrl_i      (sys_ctrl),
        .isl_pix_i       (isl_pix),
        .hdmirx_pix_i    (hdmirx_pix),
        .isl_datavalid_i (isl_datavalid),
        .osd_enable_i    (osd_enable),
        .osd_color_i     (osd_color),
        .resync_strobe_i (resync_strobe),
        .pll_locked_i    (pll_locked),
        .hdmitx_pix_o    (hdmitx_pix),
        .led_o           (led),
        .fan_pwm_n_o     (fan_pwm_n)
    );

    initial begin
        pclk_out = 1'b0;
        forever #2 pclk_out = ~pclk_out;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAIL %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    function automatic logic [23:0] palette_rgb(input ossc_out_pkg::osd_color_e color);
        case (color)
            ossc_out_pkg::osd_black: return 24'h000000;
            ossc_out_pkg::osd_blue: return 24'h0000ff;
            ossc_out_pkg::osd_yellow: return 24'hffff00;
            default: return 24'hffffff;
        endcase
    endfunction

    function automatic ossc_out_pkg::video_pixel_t expected_pixel(input table_entry_t e);
        ossc_out_pkg::video_pixel_t p;
        if (e.capture_sel) begin
            p = e.hdmi_pix;
        end else begin
            // Digitizer data-valid gates DE
            p = e.isl_pix;
            p.de = p.de & e.datavalid;
        end
        if (e.osd_enable) begin
            {p.r, p.g, p.b} = palette_rgb(e.osd_color);
        end
        return p;
    endfunction

    task automatic add_entry(input int idx, input logic sel, input logic dv, input logic de,
                             input logic osd_en, input ossc_out_pkg::osd_color_e color);
        table_entry_t e;
        logic [31:0] rnd;
        rnd = $random(seed);
        e.isl_pix = rnd[$bits(ossc_out_pkg::video_pixel_t)-1:0];
        rnd = $random(seed);
        e.hdmi_pix = rnd[$bits(ossc_out_pkg::video_pixel_t)-1:0];
        e.isl_pix.de = de;
        e.hdmi_pix.de = de;
        e.capture_sel = sel;
        e.datavalid = dv;
        e.osd_enable = osd_en;
        e.osd_color = color;
        e.exp_pix = expected_pixel(e);
        stim_table[idx] = e;
    endtask

    task automatic build_table();
        logic [31:0] rnd;
        add_entry(0, 1'b0, 1'b1, 1'b1, 1'b0, ossc_out_pkg::osd_black);
        add_entry(1, 1'b0, 1'b0, 1'b1, 1'b0, ossc_out_pkg::osd_black);
        add_entry(2, 1'b0, 1'b1, 1'b0, 1'b0, ossc_out_pkg::osd_black);
        add_entry(3, 1'b0, 1'b0, 1'b0, 1'b0, ossc_out_pkg::osd_black);
        add_entry(4, 1'b1, 1'b0, 1'b1, 1'b0, ossc_out_pkg::osd_black);
        add_entry(5, 1'b1, 1'b1, 1'b1, 1'b0, ossc_out_pkg::osd_black);
        add_entry(6, 1'b1, 1'b0, 1'b0, 1'b0, ossc_out_pkg::osd_black);
        // Palette codes back to back on both sources
        for (int i = 0; i < 4; i++) begin
            add_entry(7 + i, 1'b0, 1'b1, 1'b1, 1'b1, ossc_out_pkg::osd_color_e'(i));
            add_entry(11 + i, 1'b1, 1'b0, 1'b1, 1'b1, ossc_out_pkg::osd_color_e'(3 - i));
        end
        for (int i = 15; i < TABLE_LEN; i++) begin
            rnd = $random(seed);
            add_entry(i, rnd[0], rnd[1], rnd[2], rnd[3], ossc_out_pkg::osd_color_e'(rnd[5:4]));
        end
    endtask

    task automatic measure_fan_low(input logic [3:0] duty, input int expected_low);
        int low_cycles;
        low_cycles = 0;
        sys_ctrl.fan_duty = duty;
        repeat (2) @(negedge pclk_out);
        repeat (ossc_out_pkg::PWM_PERIOD) begin
            @(negedge pclk_out);
            if (!fan_pwm_n) begin
                low_cycles++;
            end
        end
        check_value("fan_pwm_n_o low cycles", 32'(low_cycles), 32'(expected_low));
    endtask

    initial begin
        po_reset_n = 1'b0;
        sys_ctrl = '0;
        sys_ctrl.sys_poweron = 1'b1;
        sys_ctrl.led_duty = 4'd15;
        isl_pix = '0;
        hdmirx_pix = '0;
        isl_datavalid = 1'b0;
        osd_enable = 1'b0;
        osd_color = ossc_out_pkg::osd_black;
        resync_strobe = 1'b0;
        pll_locked = 1'b1;
        build_table();

        repeat (3) @(negedge pclk_out);
        check_value("hdmitx_pix_o", 32'(hdmitx_pix), 32'd0);
        check_value("led_o", 32'(led), 32'd0);
        check_value("fan_pwm_n_o", 32'(fan_pwm_n), 32'd1);
        po_reset_n = 1'b1;

        // OSD controls trail their pixel by one cycle
        for (int n = 0; n < TABLE_LEN + 3; n++) begin
            if (n >= 3) begin
                check_value("hdmitx_pix_o", 32'(hdmitx_pix), 32'(stim_table[n-3].exp_pix));
            end
            if (n < TABLE_LEN) begin
                sys_ctrl.capture_sel = stim_table[n].capture_sel;
                isl_pix = stim_table[n].isl_pix;
                hdmirx_pix = stim_table[n].hdmi_pix;
                isl_datavalid = stim_table[n].datavalid;
            end
            if (n >= 1 && n <= TABLE_LEN) begin
                osd_enable = stim_table[n-1].osd_enable;
                osd_color = stim_table[n-1].osd_color;
            end
            @(negedge pclk_out);
        end

        measure_fan_low(4'd15, 15 * ossc_out_pkg::PWM_STEP);
        measure_fan_low(4'd0, 0);
        measure_fan_low(4'd8, 8 * ossc_out_pkg::PWM_STEP);

        // Two sync flops, edge detect, then the counter load
        resync_strobe = 1'b1;
        repeat (3) @(negedge pclk_out);
        check_value("led_o[0]", 32'(led[0]), 32'd0);
        @(negedge pclk_out);
        check_value("led_o[0]", 32'(led[0]), 32'd1);
        resync_strobe = 1'b0;
        repeat (RESYNC_SPAN - 2) @(negedge pclk_out);
        check_value("led_o[0]", 32'(led[0]), 32'd1);
        repeat (2) @(negedge pclk_out);
        check_value("led_o[0]", 32'(led[0]), 32'd0);

        sys_ctrl.framelock = 1'b1;
        @(negedge pclk_out);
        check_value("led_o[1]", 32'(led[1]), 32'd1);
        sys_ctrl.framelock = 1'b0;
        @(negedge pclk_out);
        check_value("led_o[1]", 32'(led[1]), 32'd0);

        // Standby
        sys_ctrl.sys_poweron = 1'b0;
        pll_locked = 1'b1;
        measure_fan_low(4'd15, 0);
        // Locked PLL holds the counter at zero so bit 0 is lit
        check_value("led_o", 32'(led), 32'd1);
        pll_locked = 1'b0;
        @(negedge pclk_out);
        check_value("led_o", 32'(led), 32'd0);
        repeat (BLINK_HALF - 1) @(negedge pclk_out);
        check_value("led_o", 32'(led), 32'd0);
        @(negedge pclk_out);
        check_value("led_o", 32'(led), 32'd1);
        // Lit for the lower half of the counter range
        repeat (BLINK_HALF - 1) @(negedge pclk_out);
        check_value("led_o", 32'(led), 32'd1);
        @(negedge pclk_out);
        check_value("led_o", 32'(led), 32'd0);

        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge pclk_out);
        $display("Timeout: tests did not complete within %0d clock cycles", WATCHDOG_CYCLES);
        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// ==== ossc_out_top.sv ====
`timescale 1ns/10ps

module ossc_out_top (
    input  logic                      pclk_out,
    input  logic                      po_reset_n,
    input  ossc_out_pkg::sys_ctrl_t    sys_ctrl_i,
    input  ossc_out_pkg::video_pixel_t isl_pix_i,
    input  ossc_out_pkg::video_pixel_t hdmirx_pix_i,
    input  logic                      isl_datavalid_i,
    input  logic                      osd_enable_i,
    input  ossc_out_pkg::osd_color_e   osd_color_i,
    input  logic                      resync_strobe_i,
    input  logic                      pll_locked_i,
    output ossc_out_pkg::video_pixel_t hdmitx_pix_o,
    output logic [1:0]                led_o,
    output logic                      fan_pwm_n_o
);

    ossc_out_pkg::video_pixel_t capt_pix;
    logic led_pwm;

    // Video path
    capture_select u_capture_select (
        .pclk_out        (pclk_out),
        .po_reset_n      (po_reset_n),
        .capture_sel_i   (sys_ctrl_i.capture_sel),
        .isl_pix_i       (isl_pix_i),
        .hdmirx_pix_i    (hdmirx_pix_i),
        .isl_datavalid_i (isl_datavalid_i),
        .capt_pix_o      (capt_pix)
    );

    osd_overlay_out u_osd_overlay_out (
        .pclk_out     (pclk_out),
        .po_reset_n   (po_reset_n),
        .pix_i        (capt_pix),
        .osd_enable_i (osd_enable_i),
        .osd_color_i  (osd_color_i),
        .hdmitx_pix_o (hdmitx_pix_o)
    );

    // Board status
    status_led u_status_led (
        .pclk_out        (pclk_out),
        .po_reset_n      (po_reset_n),
        .resync_strobe_i (resync_strobe_i),
        .pll_locked_i    (pll_locked_i),
        .poweron_i       (sys_ctrl_i.sys_poweron),
        .framelock_i     (sys_ctrl_i.framelock),
        .led_pwm_i       (led_pwm),
        .led_o           (led_o)
    );

    fan_led_pwm u_fan_led_pwm (
        .pclk_out    (pclk_out),
        .po_reset_n  (po_reset_n),
        .fan_duty_i  (sys_ctrl_i.fan_duty),
        .led_duty_i  (sys_ctrl_i.led_duty),
        .poweron_i   (sys_ctrl_i.sys_poweron),
        .fan_pwm_n_o (fan_pwm_n_o),
        .led_pwm_o   (led_pwm)
    );

endmodule

// ==== fan_led_pwm.sv ====
`timescale 1ns/10ps

module fan_led_pwm (
    input  logic                            pclk_out,
    input  logic                            po_reset_n,
    input  logic [ossc_out_pkg::DUTY_W-1:0] fan_duty_i,
    input  logic [ossc_out_pkg::DUTY_W-1:0] led_duty_i,
    input  logic                            poweron_i,
    output logic                            fan_pwm_n_o,
    output logic                            led_pwm_o
);

    logic [ossc_out_pkg::PWM_CTR_W-1:0] pwm_ctr;
    logic [ossc_out_pkg::DUTY_W-1:0] pwm_step_idx;

    // Shared period counter
    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            pwm_ctr <= '0;
        end else if (pwm_ctr == ossc_out_pkg::PWM_LAST) begin
            pwm_ctr <= '0;
        end else begin
            pwm_ctr <= pwm_ctr + 1'b1;
        end
    end

    // ctr < duty * step is the same as step index < duty
    assign pwm_step_idx = pwm_ctr[ossc_out_pkg::PWM_CTR_W-1:ossc_out_pkg::PWM_STEP_W];

    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            fan_pwm_n_o <= 1'b1;
            led_pwm_o <= 1'b0;
        end else begin
            // Fan driver is active low and only runs when powered on
            fan_pwm_n_o <= ~(poweron_i & (pwm_step_idx < fan_duty_i));
            led_pwm_o <= pwm_step_idx < led_duty_i;
        end
    end

endmodule

// ==== status_led.sv ====
`timescale 1ns/10ps

module status_led (
    input  logic       pclk_out,
    input  logic       po_reset_n,
    input  logic       resync_strobe_i,
    input  logic       pll_locked_i,
    input  logic       poweron_i,
    input  logic       framelock_i,
    input  logic       led_pwm_i,
    output logic [1:0] led_o
);

    logic resync_sync1;
    logic resync_sync2;
    logic resync_prev;
    logic resync_rise;
    logic [ossc_out_pkg::RESYNC_CTR_W-1:0] resync_ctr;
    logic [1:0] led_pattern;

    // Strobe comes from another clock domain
    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            resync_sync1 <= 1'b0;
            resync_sync2 <= 1'b0;
            resync_prev <= 1'b0;
            resync_rise <= 1'b0;
        end else begin
            resync_sync1 <= resync_strobe_i;
            resync_sync2 <= resync_sync1;
            resync_prev <= resync_sync2;
            resync_rise <= resync_sync2 & ~resync_prev;
        end
    end

    // Indicator countdown, free-running blink timer in standby
    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            resync_ctr <= '0;
        end else if (poweron_i) begin
            if (resync_rise) begin
                resync_ctr <= '1;
            end else if (resync_ctr != '0) begin
                resync_ctr <= resync_ctr - 1'b1;
            end
        end else begin
            if (pll_locked_i) begin
                resync_ctr <= '0;
            end else begin
                resync_ctr <= resync_ctr - 1'b1;
            end
        end
    end

    always_comb begin
        if (poweron_i) begin
            led_pattern = {framelock_i, (resync_ctr != '0)};
        end else begin
            // PLL not locked blink
            led_pattern = {1'b0, ~resync_ctr[ossc_out_pkg::RESYNC_CTR_W-1]};
        end
    end

    assign led_o = {2{led_pwm_i}} & led_pattern;

endmodule

// ==== osd_overlay_out.sv ====
`timescale 1ns/10ps

module osd_overlay_out (
    input  logic                      pclk_out,
    input  logic                      po_reset_n,
    input  ossc_out_pkg::video_pixel_t pix_i,
    input  logic                      osd_enable_i,
    input  ossc_out_pkg::osd_color_e   osd_color_i,
    output ossc_out_pkg::video_pixel_t hdmitx_pix_o
);

    logic [ossc_out_pkg::RGB_W-1:0] osd_rgb;
    ossc_out_pkg::video_pixel_t pix_out;

    // Fixed four-entry palette
    always_comb begin
        case (osd_color_i)
            ossc_out_pkg::osd_black: begin
                osd_rgb = ossc_out_pkg::OSD_RGB_BLACK;
            end
            ossc_out_pkg::osd_blue: begin
                osd_rgb = ossc_out_pkg::OSD_RGB_BLUE;
            end
            ossc_out_pkg::osd_yellow: begin
                osd_rgb = ossc_out_pkg::OSD_RGB_YELLOW;
            end
            default: begin
                osd_rgb = ossc_out_pkg::OSD_RGB_WHITE;
            end
        endcase
    end

    // Overlay stage, syncs and DE pass unchanged
    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            pix_out <= '0;
        end else begin
            pix_out <= pix_i;
            if (osd_enable_i) begin
                {pix_out.r, pix_out.g, pix_out.b} <= osd_rgb;
            end
        end
    end

    // Launch register toward the transmitter
    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            hdmitx_pix_o <= '0;
        end else begin
            hdmitx_pix_o <= pix_out;
        end
    end

endmodule

// ==== capture_select.sv ====
`timescale 1ns/10ps

module capture_select (
    input  logic                      pclk_out,
    input  logic                      po_reset_n,
    input  logic                      capture_sel_i,
    input  ossc_out_pkg::video_pixel_t isl_pix_i,
    input  ossc_out_pkg::video_pixel_t hdmirx_pix_i,
    input  logic                      isl_datavalid_i,
    output ossc_out_pkg::video_pixel_t capt_pix_o
);

    ossc_out_pkg::video_pixel_t sel_pix;
    logic sel_valid;

    // 0 selects the digitizer, 1 the HDMI receiver
    always_comb begin
        if (capture_sel_i) begin
            sel_pix = hdmirx_pix_i;
        end else begin
            sel_pix = isl_pix_i;
        end

        // HDMI receiver delivers a valid pixel every cycle
        sel_valid = capture_sel_i | isl_datavalid_i;

        sel_pix.de = sel_pix.de & sel_valid;
    end

    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            capt_pix_o <= '0;
        end else begin
            capt_pix_o <= sel_pix;
        end
    end

endmodule

// ==== ossc_out_pkg.sv ====
package ossc_out_pkg;

    // Video channel width
    localparam int COLOR_W = 8;
    localparam int RGB_W = 3 * COLOR_W;

    // Resync indicator counter, shortened from the board's 24 bits
    localparam int RESYNC_CTR_W = 12;

    // PWM timing
    localparam int DUTY_W = 4;
    localparam int PWM_STEP_W = 6;
    localparam int PWM_STEP = 1 << PWM_STEP_W;
    localparam int PWM_PERIOD = 15 * PWM_STEP;
    localparam int PWM_CTR_W = $clog2(PWM_PERIOD);
    localparam logic [PWM_CTR_W-1:0] PWM_LAST = PWM_CTR_W'(PWM_PERIOD - 1);

    // OSD palette colours, {r, g, b}
    localparam logic [RGB_W-1:0] OSD_RGB_BLACK = 24'h000000;
    localparam logic [RGB_W-1:0] OSD_RGB_BLUE = 24'h0000ff;
    localparam logic [RGB_W-1:0] OSD_RGB_YELLOW = 24'hffff00;
    localparam logic [RGB_W-1:0] OSD_RGB_WHITE = 24'hffffff;

    typedef enum logic [1:0] {
        osd_black = 2'd0,
        osd_blue = 2'd1,
        osd_yellow = 2'd2,
        osd_white = 2'd3
    } osd_color_e;

    // One pixel with its syncs and data enable
    typedef struct packed {
        logic [COLOR_W-1:0] r;
        logic [COLOR_W-1:0] g;
        logic [COLOR_W-1:0] b;
        logic hsync;
        logic vsync;
        logic de;
    } video_pixel_t;

    // System control word, laid out as on the board
    typedef struct packed {
        logic [7:0] reserved_hi;
        logic [DUTY_W-1:0] led_duty;
        logic [DUTY_W-1:0] fan_duty;
        logic reserved_15;
        logic framelock;
        // Front-end resets, polarities, test pattern and CSC on the board
        logic [5:0] reserved_mid;
        logic capture_sel;
        // Receiver and memory resets on the board
        logic [5:0] reserved_lo;
        logic sys_poweron;
    } sys_ctrl_t;

endpackage
